/* logic/iq_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_dispatch #(
	parameter int DEPTH = iq_pkg::DEFAULT_DEPTH
) (
	input  wire                               write_en,
	input  wire iq_pkg::lane_num_t            write_num,
	input  wire iq_pkg::entry_t               din0,
	input  wire iq_pkg::entry_t               din1,
	input  wire iq_pkg::entry_t               din2,
	input  wire iq_pkg::entry_t               din3,
	input  wire iq_pkg::count_t               count,
	input  wire iq_pkg::shift_t               issued_num,
	output logic [DEPTH-1:0]                  slot_we,
	output iq_pkg::entry_t [DEPTH-1:0]        slot_wdata,
	output iq_pkg::lane_num_t                 alloc_num,
	output logic                              write_success
);

	typedef logic [iq_pkg::SLOT_WIDTH:0] sum_t;  // one bit more than count, holds ptr plus lanes

	iq_pkg::entry_t [iq_pkg::DISPATCH_WIDTH-1:0] lane_data;
	iq_pkg::count_t wr_ptr;
	sum_t           wr_end;
	logic           wr_go;

	assign lane_data = {din3, din2, din1, din0};

	// --------------------
	// acceptance

	assign wr_ptr = count - iq_pkg::count_t'(issued_num);  // first free slot once issues leave
	assign wr_end = sum_t'(wr_ptr) + sum_t'(write_num);
	assign write_success = (wr_end <= sum_t'(DEPTH));  // all or nothing, never a partial write
	assign wr_go = write_en & write_success;
	assign alloc_num = wr_go ? write_num : '0;

	// --------------------
	// lane steering

	// lane k lands right behind the survivors, in lane order
	always_comb begin
		slot_we = '0;
		slot_wdata = '0;
		for (int i = 0; i < DEPTH; i++) begin
			for (int k = 0; k < iq_pkg::DISPATCH_WIDTH; k++) begin
				if (wr_go && k < int'(write_num) && i == int'(wr_ptr) + k) begin
					slot_we[i] = 1'b1;
					slot_wdata[i] = lane_data[k];
				end
			end
		end
	end

	always_comb begin
		if (write_en) begin
			assert final (write_num <= iq_pkg::lane_num_t'(iq_pkg::DISPATCH_WIDTH))
			else $error("iq_dispatch: write_num %0d exceeds the dispatch lanes", write_num);
		end
	end

endmodule

`default_nettype wire

/* logic/iq_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_entry_array #(
	parameter int DEPTH = iq_pkg::DEFAULT_DEPTH
) (
	input  wire                               clk,
	input  wire                               resetn,
	input  wire iq_pkg::shift_t [DEPTH-1:0]   shift_sel,
	input  wire iq_pkg::shift_t               issued_num,
	input  wire [DEPTH-1:0]                   slot_we,
	input  wire iq_pkg::entry_t [DEPTH-1:0]   slot_wdata,
	input  wire iq_pkg::lane_num_t            alloc_num,
	output iq_pkg::entry_t [DEPTH-1:0]        entries,
	output iq_pkg::count_t                    count
);

	localparam int SPAN = DEPTH + iq_pkg::ISSUE_WIDTH;  // room to look past the last slot

	iq_pkg::entry_t [SPAN-1:0]  padded;
	iq_pkg::entry_t [DEPTH-1:0] entries_next;
	iq_pkg::count_t             count_next;

	// --------------------
	// compaction

	// slots past the end read as empty so the tail fills with zero
	always_comb begin
		padded = '0;
		padded[DEPTH-1:0] = entries;
	end

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			entries_next[i] = '0;
			for (int d = 0; d <= iq_pkg::ISSUE_WIDTH; d++) begin
				if (shift_sel[i] == iq_pkg::shift_t'(d)) begin
					entries_next[i] = padded[i+d];  // survivor from d slots above
				end
			end
			if (slot_we[i]) begin
				entries_next[i] = slot_wdata[i];  // a new word wins over any shift
			end
		end
	end

	assign count_next = count - iq_pkg::count_t'(issued_num) + iq_pkg::count_t'(alloc_num);

	// --------------------
	// state

	always_ff @(posedge clk) begin
		if (!resetn) begin
			entries <= '0;
			count <= '0;
		end else begin
			entries <= entries_next;
			count <= count_next;
		end
	end

	// dispatch acceptance and issue accounting together must keep the queue in bounds
	assert property (@(posedge clk) disable iff (!resetn) count <= iq_pkg::count_t'(DEPTH))
	else $error("iq_entry_array: count %0d above depth %0d", count, DEPTH);

endmodule

`default_nettype wire

/* logic/iq_issue_select.sv */
`timescale 1ns/1ps
`default_nettype none

module iq_issue_select #(
	parameter int DEPTH = iq_pkg::DEFAULT_DEPTH
) (
	input  wire iq_pkg::entry_t [DEPTH-1:0]   entries,
	input  wire iq_pkg::count_t               count,
	input  wire                               issue_en0,
	input  wire                               issue_en1,
	input  wire iq_pkg::slot_t                issue_idx0,
	input  wire iq_pkg::slot_t                issue_idx1,
	output iq_pkg::entry_t                    dout0,
	output iq_pkg::entry_t                    dout1,
	output iq_pkg::shift_t                    issued_num,
	output iq_pkg::shift_t [DEPTH-1:0]        shift_sel
);

	localparam int SPAN = DEPTH + iq_pkg::ISSUE_WIDTH;

	logic [DEPTH-1:0]          hit0;
	logic [DEPTH-1:0]          hit1;
	logic [SPAN-1:0]           remove;
	iq_pkg::shift_t [SPAN-1:0] removed_upto;  // removed slots at or below each position

	// --------------------
	// read ports

	always_comb begin
		for (int j = 0; j < DEPTH; j++) begin
			hit0[j] = issue_en0 && issue_idx0 == iq_pkg::slot_t'(j);
			hit1[j] = issue_en1 && issue_idx1 == iq_pkg::slot_t'(j);
		end
	end

	always_comb begin
		dout0 = '0;
		dout1 = '0;
		for (int j = 0; j < DEPTH; j++) begin
			if (hit0[j]) begin
				dout0 = entries[j];
			end
			if (hit1[j]) begin
				dout1 = entries[j];
			end
		end
	end

	assign issued_num = iq_pkg::shift_t'(issue_en0) + iq_pkg::shift_t'(issue_en1);

	// --------------------
	// shift amounts

	always_comb begin
		remove = '0;
		remove[DEPTH-1:0] = hit0 | hit1;  // the issued slot is exactly the one removed
	end

	always_comb begin
		iq_pkg::shift_t seen;
		seen = '0;
		for (int j = 0; j < SPAN; j++) begin
			seen = seen + iq_pkg::shift_t'(remove[j]);
			removed_upto[j] = seen;
		end
	end

	// slot i takes the survivor at i+d that has exactly d removed slots at or below it
	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			shift_sel[i] = issued_num;
			for (int d = iq_pkg::ISSUE_WIDTH; d >= 0; d--) begin
				if (!remove[i+d] && removed_upto[i+d] == iq_pkg::shift_t'(d)) begin
					shift_sel[i] = iq_pkg::shift_t'(d);
				end
			end
		end
	end

	always_comb begin
		if (issue_en0) begin
			assert final (issue_idx0 < count)
			else $error("iq_issue_select: issue_idx0 %0d not below count %0d", issue_idx0, count);
		end
		if (issue_en1) begin
			assert final (issue_idx1 < count)
			else $error("iq_issue_select: issue_idx1 %0d not below count %0d", issue_idx1, count);
		end
		if (issue_en0 && issue_en1) begin
			assert final (issue_idx0 != issue_idx1)
			else $error("iq_issue_select: both ports name slot %0d", issue_idx0);
		end
	end

endmodule

`default_nettype wire

/* logic/iq_pkg.sv */
`default_nettype none

package iq_pkg;

	// --------------------
	// queue geometry

	localparam int ENTRY_WIDTH    = 32;
	localparam int DISPATCH_WIDTH = 4;  // words a single dispatch can carry
	localparam int ISSUE_WIDTH    = 2;  // read ports, also the largest compaction step
	localparam int DEFAULT_DEPTH  = 7;
	localparam int MAX_DEPTH      = 15;

	localparam int SLOT_WIDTH  = $clog2(MAX_DEPTH + 1);
	localparam int LANE_WIDTH  = $clog2(DISPATCH_WIDTH + 1);
	localparam int SHIFT_WIDTH = $clog2(ISSUE_WIDTH + 1);

	// --------------------
	// shared types

	typedef logic [ENTRY_WIDTH-1:0] entry_t;     // one dispatched micro-op word
	typedef logic [SLOT_WIDTH-1:0]  slot_t;      // slot index
	typedef logic [SLOT_WIDTH-1:0]  count_t;     // occupancy, 0 up to MAX_DEPTH
	typedef logic [LANE_WIDTH-1:0]  lane_num_t;  // words in one dispatch, 0 to 4
	typedef logic [SHIFT_WIDTH-1:0] shift_t;     // distance a survivor moves down

endpackage

`default_nettype wire

/* logic/issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
	parameter int DEPTH = iq_pkg::DEFAULT_DEPTH
) (
	input  wire                      clk,
	input  wire                      resetn,
	input  wire                      write_en,
	input  wire iq_pkg::lane_num_t   write_num,
	input  wire iq_pkg::entry_t      din0,
	input  wire iq_pkg::entry_t      din1,
	input  wire iq_pkg::entry_t      din2,
	input  wire iq_pkg::entry_t      din3,
	input  wire                      issue_en0,
	input  wire                      issue_en1,
	input  wire iq_pkg::slot_t       issue_idx0,
	input  wire iq_pkg::slot_t       issue_idx1,
	output wire iq_pkg::entry_t      dout0,
	output wire iq_pkg::entry_t      dout1,
	output wire iq_pkg::count_t      count,
	output wire                      write_success
);

	wire iq_pkg::entry_t [DEPTH-1:0] entries;
	wire iq_pkg::shift_t [DEPTH-1:0] shift_sel;
	wire iq_pkg::shift_t             issued_num;
	wire [DEPTH-1:0]                 slot_we;
	wire iq_pkg::entry_t [DEPTH-1:0] slot_wdata;
	wire iq_pkg::lane_num_t          alloc_num;

	// --------------------
	// dispatch, entries, issue

	iq_dispatch #(.DEPTH(DEPTH)) u_dispatch (
		.write_en      (write_en),
		.write_num     (write_num),
		.din0          (din0),
		.din1          (din1),
		.din2          (din2),
		.din3          (din3),
		.count         (count),
		.issued_num    (issued_num),  // frees slots in the same cycle
		.slot_we       (slot_we),
		.slot_wdata    (slot_wdata),
		.alloc_num     (alloc_num),
		.write_success (write_success)
	);

	iq_entry_array #(.DEPTH(DEPTH)) u_array (
		.clk        (clk),
		.resetn     (resetn),
		.shift_sel  (shift_sel),
		.issued_num (issued_num),
		.slot_we    (slot_we),
		.slot_wdata (slot_wdata),
		.alloc_num  (alloc_num),
		.entries    (entries),
		.count      (count)
	);

	iq_issue_select #(.DEPTH(DEPTH)) u_select (
		.entries    (entries),
		.count      (count),
		.issue_en0  (issue_en0),
		.issue_en1  (issue_en1),
		.issue_idx0 (issue_idx0),
		.issue_idx1 (issue_idx1),
		.dout0      (dout0),
		.dout1      (dout1),
		.issued_num (issued_num),
		.shift_sel  (shift_sel)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
	--top-module tb_issue_queue \
	-Mdir obj_dir \
	-f sources.f

./obj_dir/Vtb_issue_queue > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

/* sources.f */
logic/iq_pkg.sv
logic/iq_dispatch.sv
logic/iq_entry_array.sv
logic/iq_issue_select.sv
logic/issue_queue.sv
testbench/tb_issue_queue.sv

/* testbench/tb_issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_issue_queue;

	localparam int DEPTH           = iq_pkg::DEFAULT_DEPTH;
	localparam int CLK_PERIOD      = 8;
	localparam int RESET_CYCLES    = 4;
	localparam int DIRECTED_CYCLES = 80;
	localparam int RANDOM_CYCLES   = 300;
	localparam int MARGIN_CYCLES   = 100;

	logic              clk;
	logic              resetn;
	logic              write_en;
	iq_pkg::lane_num_t write_num;
	iq_pkg::entry_t    din0, din1, din2, din3;
	logic              issue_en0, issue_en1;
	iq_pkg::slot_t     issue_idx0, issue_idx1;
	iq_pkg::entry_t    dout0, dout1;
	iq_pkg::count_t    count;
	logic              write_success;

	iq_pkg::entry_t [DEPTH-1:0] model_q;  // queue contents in arrival order
	iq_pkg::count_t             model_cnt;
	logic [31:0]                lfsr_state;
	int                         tag;

	issue_queue #(.DEPTH(DEPTH)) dut (
		.clk (clk), .resetn (resetn), .write_en (write_en), .write_num (write_num),
		.din0 (din0), .din1 (din1), .din2 (din2), .din3 (din3),
		.issue_en0 (issue_en0), .issue_en1 (issue_en1),
		.issue_idx0 (issue_idx0), .issue_idx1 (issue_idx1),
		.dout0 (dout0), .dout1 (dout1), .count (count), .write_success (write_success)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------
	// reference model

	function automatic void ref_step(
		input iq_pkg::entry_t [DEPTH-1:0] cur, input iq_pkg::count_t cur_cnt,
		input logic we, input iq_pkg::lane_num_t wn, input iq_pkg::entry_t [3:0] din,
		input logic e0, input logic e1, input iq_pkg::slot_t i0, input iq_pkg::slot_t i1,
		output iq_pkg::entry_t x0, output iq_pkg::entry_t x1, output logic ws,
		output iq_pkg::entry_t [DEPTH-1:0] nxt, output iq_pkg::count_t nxt_cnt);
		int left;
		int surv;
		left = int'(cur_cnt) - int'(e0) - int'(e1);
		x0 = (e0 && int'(i0) < DEPTH) ? cur[i0] : '0;
		x1 = (e1 && int'(i1) < DEPTH) ? cur[i1] : '0;
		ws = (left + int'(wn) <= DEPTH);  // all words must fit once issues have left
		nxt = '0;
		surv = 0;
		for (int j = 0; j < int'(cur_cnt); j++) begin
			if (!(e0 && int'(i0) == j) && !(e1 && int'(i1) == j)) begin
				nxt[surv] = cur[j];
				surv++;
			end
		end
		if (we && ws) begin
			for (int k = 0; k < int'(wn); k++) begin
				nxt[surv+k] = din[k];  // accepted words follow the survivors
			end
			surv = surv + int'(wn);
		end
		nxt_cnt = iq_pkg::count_t'(surv);
	endfunction

	// --------------------
	// compare tasks

	task check_entry(input string name, input iq_pkg::entry_t got, input iq_pkg::entry_t exp);
		if (got !== exp) begin
			$display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task check_count(input string name, input iq_pkg::count_t got, input iq_pkg::count_t exp);
		if (got !== exp) begin
			$display("Fail at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at time %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// checks land one ns before the next rising edge once every output has settled
	always begin
		iq_pkg::entry_t            x0, x1;
		logic                      ws;
		iq_pkg::entry_t [DEPTH-1:0] nxt;
		iq_pkg::count_t            nxt_cnt;
		@(posedge clk);
		#(CLK_PERIOD - 1);
		if (!resetn) begin
			model_q = '0;
			model_cnt = '0;
		end else begin
			ref_step(model_q, model_cnt, write_en, write_num, {din3, din2, din1, din0},
				issue_en0, issue_en1, issue_idx0, issue_idx1, x0, x1, ws, nxt, nxt_cnt);
			check_count("count", count, model_cnt);
			check_entry("dout0", dout0, x0);
			check_entry("dout1", dout1, x1);
			check_bit("write_success", write_success, ws);
			model_q = nxt;
			model_cnt = nxt_cnt;
		end
	end

	// --------------------
	// stimulus helpers

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
	endfunction

	task draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task drive(input logic we, input iq_pkg::lane_num_t wn, input iq_pkg::entry_t w,
		input logic e0, input iq_pkg::slot_t i0, input logic e1, input iq_pkg::slot_t i1);
		write_en <= we;
		write_num <= wn;
		din0 <= w;
		din1 <= w + 32'd1;
		din2 <= w + 32'd2;
		din3 <= w + 32'd3;
		issue_en0 <= e0;
		issue_idx0 <= i0;
		issue_en1 <= e1;
		issue_idx1 <= i1;
	endtask

	task run_cycle(input logic we, input iq_pkg::lane_num_t wn,
		input logic e0, input iq_pkg::slot_t i0, input logic e1, input iq_pkg::slot_t i1);
		@(posedge clk);
		tag++;
		drive(we, wn, iq_pkg::entry_t'(32'h1000_0000 + tag * 16), e0, i0, e1, i1);
	endtask

	task drain_queue(input logic dual);
		@(posedge clk);
		while (model_cnt != 4'd0) begin
			drive(1'b0, 3'd0, 32'd0, 1'b1, 4'd0, dual && model_cnt > 4'd1, 4'd1);
			@(posedge clk);
		end
		drive(1'b0, 3'd0, 32'd0, 1'b0, 4'd0, 1'b0, 4'd0);
	endtask

	task random_cycle();
		logic [31:0]       r;
		int                cnt;
		logic              we, e0, e1;
		iq_pkg::lane_num_t wn;
		iq_pkg::entry_t    w;
		iq_pkg::slot_t     i0, i1;
		@(posedge clk);
		cnt = int'(model_cnt);
		draw_bits(1, r);
		we = r[0];
		draw_bits(3, r);
		wn = iq_pkg::lane_num_t'(r % 5);
		draw_bits(32, r);
		w = r;
		draw_bits(1, r);
		e0 = r[0] && cnt >= 1;
		draw_bits(4, r);
		i0 = (cnt >= 1) ? iq_pkg::slot_t'(r % cnt) : 4'd0;
		draw_bits(1, r);
		e1 = r[0] && cnt >= 2;
		draw_bits(4, r);
		i1 = (cnt >= 1) ? iq_pkg::slot_t'(r % cnt) : 4'd0;
		if (e0 && e1 && i1 == i0) begin
			i1 = iq_pkg::slot_t'((int'(i0) + 1) % cnt);  // the two ports never share a slot
		end
		drive(we, wn, w, e0, i0, e1, i1);
	endtask

	// --------------------
	// test sequence

	initial begin
		#((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("timeout: the test sequence did not finish in time");
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		model_q = '0;
		model_cnt = '0;
		lfsr_state = 32'hd88b;
		tag = 0;
		write_en = 1'b0;
		write_num = '0;
		din0 = '0;
		din1 = '0;
		din2 = '0;
		din3 = '0;
		issue_en0 = 1'b0;
		issue_en1 = 1'b0;
		issue_idx0 = '0;
		issue_idx1 = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		resetn <= 1'b1;
		#(CLK_PERIOD - 1);
		check_count("count", count, 4'd0);  // empty and idle right after reset
		check_entry("dout0", dout0, 32'd0);
		check_entry("dout1", dout1, 32'd0);
		check_bit("write_success", write_success, 1'b1);

		run_cycle(1'b1, 3'd1, 1'b0, 4'd0, 1'b0, 4'd0);  // fill with 1, 2 then 4 words
		run_cycle(1'b1, 3'd2, 1'b0, 4'd0, 1'b0, 4'd0);
		run_cycle(1'b1, 3'd4, 1'b0, 4'd0, 1'b0, 4'd0);
		drain_queue(1'b0);

		run_cycle(1'b1, 3'd4, 1'b0, 4'd0, 1'b0, 4'd0);
		run_cycle(1'b1, 3'd3, 1'b0, 4'd0, 1'b0, 4'd0);
		run_cycle(1'b0, 3'd0, 1'b1, 4'd2, 1'b1, 4'd4);  // two gaps in the middle
		drain_queue(1'b0);

		run_cycle(1'b1, 3'd4, 1'b0, 4'd0, 1'b0, 4'd0);
		run_cycle(1'b1, 3'd3, 1'b0, 4'd0, 1'b0, 4'd0);
		run_cycle(1'b1, 3'd2, 1'b1, 4'd1, 1'b1, 4'd3);  // write while two leave
		drain_queue(1'b1);

		run_cycle(1'b1, 3'd4, 1'b0, 4'd0, 1'b0, 4'd0);
		run_cycle(1'b1, 3'd3, 1'b0, 4'd0, 1'b0, 4'd0);
		run_cycle(1'b1, 3'd3, 1'b1, 4'd0, 1'b0, 4'd0);  // three words offered for one free slot
		#(CLK_PERIOD - 1);
		check_bit("write_success", write_success, 1'b0);
		run_cycle(1'b1, 3'd2, 1'b1, 4'd0, 1'b1, 4'd1);
		drain_queue(1'b1);

		repeat (RANDOM_CYCLES) random_cycle();
		@(posedge clk);
		drive(1'b0, 3'd0, 32'd0, 1'b0, 4'd0, 1'b0, 4'd0);
		@(posedge clk);
		@(posedge clk);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
